/* list.f */
src/layer_pkg.sv
src/lane_capture.sv
src/benes_router.sv
src/mac_pe.sv
src/result_stage.sv
src/layer_top.sv
verif/tb_clock.sv
verif/tb_layer.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the verdict line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_layer -f list.f --Mdir obj_dir -o tb_layer ||
	{ echo "run.sh: build failed"; exit 1; }
out=$(./obj_dir/tb_layer 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS" &&
	echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }

/* src/benes_router.sv */
`timescale 1ns/1ps
`default_nettype none

module benes_router
	import layer_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  in_valid,
	input  wire logic  in_first,
	input  wire data_t lanes_in [LANES],
	input  wire sel_t  sel,
	output logic       out_valid,
	output logic       out_first,
	output data_t      lanes_out [LANES]
);

	// 2x2 switch leg: bar passes x, cross passes y
	// top leg = pick(top, bot, s), bottom leg = pick(bot, top, s)
	function automatic data_t pick(input data_t x, input data_t y, input logic s);
		return s ? y : x;
	endfunction

	data_t a [LANES]; // after stage 0
	data_t b [LANES]; // after middle stage
	data_t c [LANES]; // after final stage, unregistered

	// stage 0, switches on lane pairs (0,1) and (2,3)
	always_comb begin
		a[0] = pick(lanes_in[0], lanes_in[1], sel[0]);
		a[1] = pick(lanes_in[1], lanes_in[0], sel[0]);
		a[2] = pick(lanes_in[2], lanes_in[3], sel[1]);
		a[3] = pick(lanes_in[3], lanes_in[2], sel[1]);
	end

	// middle stage, fed (a0,a2) and (a1,a3)
	always_comb begin
		b[0] = pick(a[0], a[2], sel[2]);
		b[1] = pick(a[2], a[0], sel[2]);
		b[2] = pick(a[1], a[3], sel[3]);
		b[3] = pick(a[3], a[1], sel[3]);
	end

	// final stage, fed (b0,b2) and (b1,b3)
	always_comb begin
		c[0] = pick(b[0], b[2], sel[4]);
		c[1] = pick(b[2], b[0], sel[4]);
		c[2] = pick(b[1], b[3], sel[5]);
		c[3] = pick(b[3], b[1], sel[5]);
	end

	// control delay alongside the lanes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
		end else begin
			out_valid <= in_valid;
			out_first <= in_first;
		end
	end

	// output register, one cycle through the network
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < LANES; i++) begin
				lanes_out[i] <= c[i];
			end
		end
	end

endmodule

`default_nettype wire

/* src/lane_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_capture
	import layer_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  in_valid,  // one-cycle strobe
	input  wire logic  first,     // window restart, only with in_valid
	input  wire data_t act_in [LANES],
	input  wire data_t wgt_in [LANES],
	input  wire sel_t  act_sel,
	input  wire sel_t  wgt_sel,
	output logic       cap_valid,
	output logic       cap_first,
	output data_t      cap_act [LANES],
	output data_t      cap_wgt [LANES],
	output sel_t       cap_act_sel,
	output sel_t       cap_wgt_sel
);

	// control bits, always sampled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cap_valid <= 1'b0;
			cap_first <= 1'b0;
		end else begin
			cap_valid <= in_valid;
			cap_first <= in_valid & first; // stray first on idle cycle dropped
		end
	end

	// lanes and selects
	// hold on idle cycles so the datapath stays quiet
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < LANES; i++) begin
				cap_act[i] <= act_in[i];
				cap_wgt[i] <= wgt_in[i];
			end
			cap_act_sel <= act_sel; // each router gets its own select
			cap_wgt_sel <= wgt_sel;
		end
	end

endmodule

`default_nettype wire

/* src/layer_pkg.sv */
`default_nettype none

package layer_pkg;

	// lane and result width
	localparam int DATA_W = 32;
	localparam int Q_FRAC = 15; // Q15 fraction bits
	localparam int LANES  = 4;

	// three stages of two 2x2 switches
	localparam int SEL_W  = 6;

	// sample edge to out_valid, capture + router + two mac + result
	localparam int PIPE_LAT = 5;

	// signed lane value or dot product
	typedef logic signed [DATA_W-1:0]   data_t;

	// full multiplier product before the Q shift
	typedef logic signed [2*DATA_W-1:0] prod_t;

	// running window sum, wraps
	typedef logic signed [DATA_W-1:0]   acc_t;

	// benes switch controls, bit k = switch k
	typedef logic [SEL_W-1:0]           sel_t;

endpackage

`default_nettype wire

/* src/layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_top
	import layer_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  in_valid,
	input  wire logic  first,
	input  wire data_t act_in [LANES],
	input  wire data_t wgt_in [LANES],
	input  wire sel_t  act_sel,
	input  wire sel_t  wgt_sel,
	output logic       out_valid,
	output data_t      dot,
	output acc_t       acc
);

	// capture -> routers
	logic  cap_valid;
	logic  cap_first;
	data_t cap_act [LANES];
	data_t cap_wgt [LANES];
	sel_t  cap_act_sel;
	sel_t  cap_wgt_sel;

	// routers -> pe
	logic  rt_valid; // from the activation router
	logic  rt_first;
	data_t rt_act [LANES];
	data_t rt_wgt [LANES];

	// pe -> result stage
	logic  sum_valid;
	logic  sum_first;
	data_t sum;

	lane_capture u_lane_capture (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.first       (first),
		.act_in      (act_in),
		.wgt_in      (wgt_in),
		.act_sel     (act_sel),
		.wgt_sel     (wgt_sel),
		.cap_valid   (cap_valid),
		.cap_first   (cap_first),
		.cap_act     (cap_act),
		.cap_wgt     (cap_wgt),
		.cap_act_sel (cap_act_sel),
		.cap_wgt_sel (cap_wgt_sel)
	);

	benes_router u_act_router (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (cap_valid),
		.in_first  (cap_first),
		.lanes_in  (cap_act),
		.sel       (cap_act_sel),
		.out_valid (rt_valid),
		.out_first (rt_first),
		.lanes_out (rt_act)
	);

	// same timing as the activation router, control taken from there
	benes_router u_wgt_router (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (cap_valid),
		.in_first  (cap_first),
		.lanes_in  (cap_wgt),
		.sel       (cap_wgt_sel),
		.out_valid (),
		.out_first (),
		.lanes_out (rt_wgt)
	);

	mac_pe u_mac_pe (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (rt_valid),
		.in_first  (rt_first),
		.act       (rt_act),
		.wgt       (rt_wgt),
		.sum_valid (sum_valid),
		.sum_first (sum_first),
		.sum       (sum)
	);

	result_stage u_result_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.sum_valid (sum_valid),
		.sum_first (sum_first),
		.sum       (sum),
		.out_valid (out_valid),
		.dot       (dot),
		.acc       (acc)
	);

endmodule

`default_nettype wire

/* src/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_pe
	import layer_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  in_valid,
	input  wire logic  in_first,
	input  wire data_t act [LANES], // routed activations
	input  wire data_t wgt [LANES], // routed weights
	output logic       sum_valid,
	output logic       sum_first,
	output data_t      sum
);

	// Q15 multiply, full signed product then back to lane width
	function automatic data_t q_mul(input data_t x, input data_t y);
		prod_t p;
		p = prod_t'(x) * prod_t'(y); // sign extended operands
		return data_t'(p >>> Q_FRAC); // arithmetic shift, keep low word
	endfunction

	data_t prod_q [LANES]; // first register, products
	logic  prod_valid;
	logic  prod_first;
	data_t sum_next;

	// adder stage input, wraps at DATA_W
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < LANES; i++) begin
			sum_next = sum_next + prod_q[i];
		end
	end

	// valid/first through both registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			sum_valid  <= 1'b0;
			sum_first  <= 1'b0;
		end else begin
			prod_valid <= in_valid;
			prod_first <= in_first;
			sum_valid  <= prod_valid;
			sum_first  <= prod_first;
		end
	end

	// product register
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < LANES; i++) begin
				prod_q[i] <= q_mul(act[i], wgt[i]);
			end
		end
	end

	// sum register
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			sum <= sum_next;
		end
	end

endmodule

`default_nettype wire

/* src/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage
	import layer_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  sum_valid,
	input  wire logic  sum_first, // restart the window with this item
	input  wire data_t sum,
	output logic       out_valid, // one-cycle pulse per item
	output data_t      dot,
	output acc_t       acc
);

	acc_t acc_next;

	// restart or extend the window, wraps on overflow
	always_comb begin
		if (sum_first) begin
			acc_next = acc_t'(sum);
		end else begin
			acc_next = acc + acc_t'(sum);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			dot       <= '0;
			acc       <= '0;
		end else begin
			out_valid <= sum_valid; // sum_valid is already a single-cycle strobe
			if (sum_valid) begin
				dot <= sum; // held until next item
				acc <= acc_next;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_NS    = 5;  // 10 ns period
	localparam int RST_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// reset low for the first 16 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1; // release off the edge
	end

endmodule

`default_nettype wire

/* verif/tb_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_layer
	import layer_pkg::*;
();

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	logic  first;
	data_t act_in [LANES];
	data_t wgt_in [LANES];
	sel_t  act_sel;
	sel_t  wgt_sel;
	logic  out_valid;
	data_t dot;
	acc_t  acc;

	logic [31:0] lfsr_state;
	int    cycle_cnt = 0;    // rising edges seen
	logic  check_idle;       // reset and idle window
	string test_name;
	acc_t  model_acc;        // window sum of the model
	data_t stim_act [LANES]; // lanes of the next item
	data_t stim_wgt [LANES];
	data_t exp_dot [$];
	acc_t  exp_acc [$];
	int    exp_cycle [$];    // send cycle of each item

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	layer_top i_layer_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.first     (first),
		.act_in    (act_in),
		.wgt_in    (wgt_in),
		.act_sel   (act_sel),
		.wgt_sel   (wgt_sel),
		.out_valid (out_valid),
		.dot       (dot),
		.acc       (acc)
	);

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// fibonacci, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// n fresh bits, one step per bit
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic halt_with_fail();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_dot(input string name, input data_t exp, input data_t got);
		if (got !== exp) begin
			$display("MISMATCH test=%s dot expected=%0d actual=%0d", name, exp, got);
			halt_with_fail();
		end
	endtask

	task automatic check_acc(input string name, input acc_t exp, input acc_t got);
		if (got !== exp) begin
			$display("MISMATCH test=%s acc expected=%0d actual=%0d", name, exp, got);
			halt_with_fail();
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int got);
		if (got != exp) begin
			$display("MISMATCH test=%s latency expected=%0d actual=%0d", name, exp, got);
			halt_with_fail();
		end
	endtask

	// lane idx after the three switch stages, bit 1 = cross
	function automatic data_t routed_lane(input data_t l [LANES], input sel_t s, input int idx);
		data_t a [LANES];
		data_t b [LANES];
		data_t o [LANES];
		a = l;
		if (s[0]) begin
			a[0] = l[1];
			a[1] = l[0];
		end
		if (s[1]) begin
			a[2] = l[3];
			a[3] = l[2];
		end
		// middle switches see (a0,a2) and (a1,a3)
		b[0] = s[2] ? a[2] : a[0];
		b[1] = s[2] ? a[0] : a[2];
		b[2] = s[3] ? a[3] : a[1];
		b[3] = s[3] ? a[1] : a[3];
		// final switches see (b0,b2) and (b1,b3)
		o[0] = s[4] ? b[2] : b[0];
		o[1] = s[4] ? b[0] : b[2];
		o[2] = s[5] ? b[3] : b[1];
		o[3] = s[5] ? b[1] : b[3];
		return o[idx];
	endfunction

	// q15 products, 64-bit then >>> 15 and low word, wrapping sum
	function automatic data_t model_dot(input data_t act [LANES], input data_t wgt [LANES],
			input sel_t asel, input sel_t wsel);
		longint p;
		data_t  total;
		total = '0;
		for (int i = 0; i < LANES; i++) begin
			p = longint'(routed_lane(act, asel, i)) * longint'(routed_lane(wgt, wsel, i));
			total = total + data_t'(p >>> Q_FRAC);
		end
		return total;
	endfunction

	task automatic fill_random();
		logic [31:0] v;
		for (int i = 0; i < LANES; i++) begin
			rand_bits(32, v);
			stim_act[i] = v;
			rand_bits(32, v);
			stim_wgt[i] = v;
		end
	endtask

	// max, min, random negative or -1
	task automatic pick_extreme(output data_t x);
		logic [31:0] v;
		rand_bits(2, v);
		case (v[1:0])
			2'd0: x = 32'sh7fff_ffff;
			2'd1: x = 32'sh8000_0000;
			2'd2: begin
				rand_bits(31, v);
				x = {1'b1, v[30:0]};
			end
			default: x = -32'sd1;
		endcase
	endtask

	task automatic fill_extreme();
		for (int i = 0; i < LANES; i++) begin
			pick_extreme(stim_act[i]);
			pick_extreme(stim_wgt[i]);
		end
	endtask

	// one item on the next cycle, model result queued
	task automatic send_item(input logic frst, input sel_t asel, input sel_t wsel);
		data_t d;
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		first    = frst;
		act_sel  = asel;
		wgt_sel  = wsel;
		for (int i = 0; i < LANES; i++) begin
			act_in[i] = stim_act[i];
			wgt_in[i] = stim_wgt[i];
		end
		d = model_dot(stim_act, stim_wgt, asel, wsel);
		model_acc = frst ? acc_t'(d) : model_acc + acc_t'(d);
		exp_dot.push_back(d);
		exp_acc.push_back(model_acc);
		exp_cycle.push_back(cycle_cnt); // cycle the item is driven in
	endtask

	task automatic idle_cycles(input int n);
		logic [31:0] v;
		repeat (n) begin
			@(posedge clk);
			#1;
			rand_bits(1, v);
			in_valid = 1'b0;
			first    = v[0]; // stray first, must be ignored
		end
	endtask

	task automatic drain_results();
		int waited;
		idle_cycles(1);
		waited = 0;
		while (exp_dot.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 8 * PIPE_LAT) begin
				$display("ERROR: %s left %0d results undelivered", test_name, exp_dot.size());
				halt_with_fail();
			end
		end
	endtask

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			waited++;
			if (waited > 64) begin
				$display("ERROR: reset was never released");
				halt_with_fail();
			end
		end
	endtask

	// outputs sampled mid-cycle, away from the edge
	always @(negedge clk) begin
		if (check_idle) begin
			if (out_valid !== 1'b0) begin
				$display("ERROR: out_valid high during reset or idle cycles");
				halt_with_fail();
			end
			check_dot(test_name, '0, dot);
			check_acc(test_name, '0, acc);
		end else if (out_valid === 1'b1) begin
			if (exp_dot.size() == 0) begin
				$display("ERROR: out_valid pulsed with no item in flight");
				halt_with_fail();
			end else begin
				check_dot(test_name, exp_dot.pop_front(), dot);
				check_acc(test_name, exp_acc.pop_front(), acc);
				check_latency(test_name, PIPE_LAT, cycle_cnt - exp_cycle.pop_front());
			end
		end
	end

	initial begin
		logic [31:0] v;
		int len;
		lfsr_state = 32'd70; // seed
		check_idle = 1'b1;
		model_acc  = '0;
		in_valid   = 1'b0;
		first      = 1'b0;
		act_sel    = '0;
		wgt_sel    = '0;
		for (int i = 0; i < LANES; i++) begin
			act_in[i] = '0;
			wgt_in[i] = '0;
		end

		test_name = "reset";
		wait_reset();
		idle_cycles(20);
		check_idle = 1'b0;

		test_name = "identity"; // back to back, every item its own window
		for (int n = 0; n < 40; n++) begin
			fill_random();
			send_item(1'b1, '0, '0);
		end
		drain_results();

		test_name = "routing";
		for (int n = 0; n < 60; n++) begin
			fill_random();
			rand_bits(13, v);
			send_item(v[12], v[5:0], v[11:6]);
			rand_bits(2, v);
			idle_cycles(int'(v[1:0])); // gap of 0..3
		end
		drain_results();

		test_name = "windows";
		for (int w = 0; w < 15; w++) begin
			rand_bits(3, v);
			len = int'(v[2:0]) + 1;
			for (int k = 0; k < len; k++) begin
				fill_random();
				rand_bits(13, v);
				send_item(k == 0, v[5:0], v[11:6]);
				if (v[12]) idle_cycles(1);
			end
		end
		drain_results();

		test_name = "extremes";
		for (int n = 0; n < 40; n++) begin
			fill_extreme();
			rand_bits(13, v);
			send_item(v[12], v[5:0], v[11:6]);
		end
		drain_results();

		idle_cycles(2 * PIPE_LAT); // catch stray pulses
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
